/* bench/fetch_tb.sv */
// testbench for fetch_top; runs prog.hex through fetch and decode and checks the delivered stream.
module fetch_tb
  import fetch_pkg::*;
();

  localparam int N_DELIVERIES  = 60;
  localparam int FIRST_TIMEOUT = 20;
  localparam int RUN_TIMEOUT   = 400;
  localparam int GAP_SEQ       = 2;  // one read plus one response cycle.
  localparam int GAP_JAL       = 4;  // one squashed slot after a jump.

  logic  clk;
  logic  reset;
  logic  id_valid;
  pc_t   id_pc;
  inst_t id_inst;
  logic  id_jump;

  inst_t prog_mem [ROM_DEPTH];  // reference copy of the program.

  // reference model state.
  pc_t   exp_pc;
  inst_t exp_inst;
  logic  exp_jump;
  pc_t   exp_target;
  int    exp_gap;
  int    gap_cnt;
  logic  prev_jal;
  pc_t   prev_pc;
  pc_t   prev_target;

  int    deliveries;
  int    fwd_jal_cnt;
  int    back_jal_cnt;
  int    reset_cycles = 0;
  int    mismatch_cnt = 0;
  int    fail_cnt     = 0;
  logic  first_ok;
  logic  run_ok;

  fetch_top uut (
    .i_clk      (clk),
    .i_reset    (reset),
    .o_id_valid (id_valid),
    .o_id_pc    (id_pc),
    .o_id_inst  (id_inst),
    .o_id_jump  (id_jump)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // rebuilds the 21-bit j-type offset field by field.
  function automatic pc_t j_type_offset(input inst_t inst);
    logic [20:0] imm;
    imm[20]    = inst[31];
    imm[19:12] = inst[19:12];
    imm[11]    = inst[20];
    imm[10:1]  = inst[30:21];
    imm[0]     = 1'b0;
    return {{11{imm[20]}}, imm};
  endfunction

  assign exp_inst   = prog_mem[exp_pc[ROM_LSB+ROM_AW-1:ROM_LSB]];
  assign exp_jump   = (exp_inst[6:0] == OPCODE_JAL);
  assign exp_target = exp_pc + j_type_offset(exp_inst);

  // expected pc follows the program, not the dut.
  always @(posedge clk) begin
    if (reset) begin
      reset_cycles <= reset_cycles + 1;
      exp_pc       <= RESET_PC;
      exp_gap      <= GAP_SEQ;  // enable to first valid.
      gap_cnt      <= 0;
      prev_jal     <= 1'b0;
      prev_pc      <= RESET_PC;
      prev_target  <= RESET_PC;
      deliveries   <= 0;
      fwd_jal_cnt  <= 0;
      back_jal_cnt <= 0;
    end else if (id_valid) begin
      gap_cnt     <= 1;
      deliveries  <= deliveries + 1;
      prev_jal    <= exp_jump;
      prev_pc     <= exp_pc;
      prev_target <= exp_target;
      if (exp_jump) begin
        exp_pc  <= exp_target;
        exp_gap <= GAP_JAL;
        if (exp_target[31] == exp_pc[31] && exp_target > exp_pc) begin
          fwd_jal_cnt <= fwd_jal_cnt + 1;
        end else begin
          back_jal_cnt <= back_jal_cnt + 1;
        end
      end else begin
        exp_pc  <= exp_pc + PC_STEP;
        exp_gap <= GAP_SEQ;
      end
    end else begin
      gap_cnt <= gap_cnt + 1;
    end
  end

  // first edge is skipped, the dut registers are still unknown there.
  a_reset_quiet: assert property (
    @(posedge clk) (reset && reset_cycles >= 1) |-> !id_valid
  ) else begin
    mismatch_cnt++;
    $display("Mismatch at time %0t: o_id_valid expected 0, actual %b", $time, $sampled(id_valid));
  end

  a_pc: assert property (
    @(posedge clk) disable iff (reset)
    id_valid |-> id_pc == exp_pc
  ) else begin
    mismatch_cnt++;
    $display("Mismatch at time %0t: o_id_pc expected %h, actual %h",
             $time, $sampled(exp_pc), $sampled(id_pc));
  end

  a_inst: assert property (
    @(posedge clk) disable iff (reset)
    id_valid |-> id_inst == exp_inst
  ) else begin
    mismatch_cnt++;
    $display("Mismatch at time %0t: o_id_inst expected %h, actual %h",
             $time, $sampled(exp_inst), $sampled(id_inst));
  end

  a_jump: assert property (
    @(posedge clk) disable iff (reset)
    id_jump == (id_valid && exp_jump)
  ) else begin
    mismatch_cnt++;
    $display("Mismatch at time %0t: o_id_jump expected %b, actual %b",
             $time, $sampled(id_valid && exp_jump), $sampled(id_jump));
  end

  a_gap: assert property (
    @(posedge clk) disable iff (reset)
    id_valid |-> gap_cnt == exp_gap
  ) else begin
    mismatch_cnt++;
    $display("Mismatch at time %0t: o_id_valid spacing expected %0d, actual %0d",
             $time, $sampled(exp_gap), $sampled(gap_cnt));
  end

  // fall-through word of a taken jal only shows up when it is the target too.
  a_wrong_path: assert property (
    @(posedge clk) disable iff (reset)
    (id_valid && prev_jal && prev_target != prev_pc + PC_STEP) |-> id_pc != prev_pc + PC_STEP
  ) else begin
    fail_cnt++;
    $display("Error at time %0t: wrong-path word at pc %h delivered after the jal at pc %h",
             $time, $sampled(id_pc), $sampled(prev_pc));
  end

  task automatic wait_first_valid(input int limit, output logic ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < limit) begin
      @(negedge clk);
      if (id_valid === 1'b1) ok = 1'b1;
      cycles++;
    end
  endtask

  task automatic wait_deliveries(input int count, input int limit, output logic ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < limit) begin
      @(negedge clk);
      if (deliveries >= count) ok = 1'b1;
      cycles++;
    end
  endtask

  initial begin
    reset = 1'b1;
    $readmemh("prog.hex", prog_mem);
    if ($isunknown(prog_mem[0])) begin
      fail_cnt++;
      $display("Error: program file could not be read");
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    wait_first_valid(FIRST_TIMEOUT, first_ok);
    run_ok = 1'b0;
    if (!first_ok) begin
      fail_cnt++;
      $display("Error: no delivery within %0d cycles after reset", FIRST_TIMEOUT);
    end else begin
      wait_deliveries(N_DELIVERIES, RUN_TIMEOUT, run_ok);
      if (!run_ok) begin
        fail_cnt++;
        $display("Error: only %0d of %0d deliveries within %0d cycles",
                 deliveries, N_DELIVERIES, RUN_TIMEOUT);
      end
    end

    if (run_ok && fwd_jal_cnt == 0) begin
      fail_cnt++;
      $display("Error: the program never took a forward jal");
    end
    if (run_ok && back_jal_cnt == 0) begin
      fail_cnt++;
      $display("Error: the program never took a backward jal");
    end

    $display("deliveries %0d, mismatches %0d, other errors %0d",
             deliveries, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
rtl/fetch_pkg.sv
rtl/fetch_pc.sv
rtl/fetch_ifu.sv
rtl/fetch_if_stage.sv
rtl/fetch_id_stage.sv
rtl/inst_rom.sv
rtl/fetch_top.sv
bench/fetch_tb.sv

/* prog.hex */
// one 32-bit instruction word per line, from word address 0 upward.
// the comment after each word gives its byte address and assembly.
00100093 // 0x00 addi x1, x0, 1
00200113 // 0x04 addi x2, x0, 2
00300193 // 0x08 addi x3, x0, 3
0140006F // 0x0c jal  x0, +0x14 (to 0x20)
FF1FF06F // 0x10 jal  x0, -0x10 (wrong path, squashed)
00500293 // 0x14 addi x5, x0, 5 (skipped)
00600313 // 0x18 addi x6, x0, 6 (skipped)
00700393 // 0x1c addi x7, x0, 7 (skipped)
00800413 // 0x20 addi x8, x0, 8 (loop head)
004000EF // 0x24 jal  x1, +4 (target is the fall-through word)
00900493 // 0x28 addi x9, x0, 9
00A00513 // 0x2c addi x10, x0, 10
FF1FF06F // 0x30 jal  x0, -0x10 (back to 0x20)
00B00593 // 0x34 addi x11, x0, 11 (wrong path, squashed)
00000013 // 0x38 addi x0, x0, 0
00000013 // 0x3c addi x0, x0, 0

/* rtl/fetch_id_stage.sv */
// decode stage; latches fetched words, resolves jal and squashes the wrong-path word behind a jump.
module fetch_id_stage
  import fetch_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset,
  // from fetch
  input  logic  i_fs_to_ds_valid,
  input  pc_t   i_fs_to_ds_pc,
  input  inst_t i_fs_to_ds_inst,
  // branch to fetch
  output logic  o_br_sel,
  output pc_t   o_br_target,
  // decoded stream
  output logic  o_id_valid,
  output pc_t   o_id_pc,
  output inst_t o_id_inst,
  output logic  o_id_jump
);

  logic  id_full_r;   // register holds an instruction.
  logic  id_pulse_r;  // instruction arrived at the last edge.
  logic  squash_r;    // held instruction is on the wrong path.
  pc_t   id_pc_r;
  inst_t id_inst_r;

  logic  is_jal;
  logic  jal_taken;
  pc_t   j_imm;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      id_full_r  <= 1'b0;
      id_pulse_r <= 1'b0;
      squash_r   <= 1'b0;
    end else begin
      id_pulse_r <= i_fs_to_ds_valid;
      if (i_fs_to_ds_valid) begin
        id_full_r <= 1'b1;
        squash_r  <= jal_taken; // word after a taken jal is dropped.
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid) begin
      id_pc_r   <= i_fs_to_ds_pc;
      id_inst_r <= i_fs_to_ds_inst;
    end
  end

  assign is_jal    = (id_inst_r[6:0] == OPCODE_JAL);
  assign jal_taken = id_full_r && is_jal && !squash_r;

  // j-type immediate, sign extended.
  assign j_imm = {{11{id_inst_r[31]}}, id_inst_r[31], id_inst_r[19:12],
                  id_inst_r[20], id_inst_r[30:21], 1'b0};

  assign o_br_sel    = jal_taken; // level, held until the next word is latched.
  assign o_br_target = id_pc_r + j_imm;

  assign o_id_valid = id_pulse_r && !squash_r;
  assign o_id_pc    = id_pc_r;
  assign o_id_inst  = id_inst_r;
  assign o_id_jump  = o_id_valid && is_jal;

  // a word latched while a jump is pending is the fall-through slot of that jump.
  a_squash_slot: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (o_br_sel && i_fs_to_ds_valid) |=> (o_id_pc == $past(o_id_pc) + PC_STEP)
  ) else $error("word latched after jal is not its fall-through slot");

  a_no_valid_squashed: assert property (
    @(posedge i_clk) disable iff (i_reset)
    squash_r |-> !o_id_valid
  ) else $error("squashed instruction marked valid");

endmodule

/* rtl/fetch_if_stage.sv */
// fetch stage; joins pc and ifu and presents valid, pc and instruction to the decode stage.
module fetch_if_stage
  import fetch_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  // branch from decode
  input  logic       i_br_sel,
  input  pc_t        i_br_target,
  // to decode
  output logic       o_fs_to_ds_valid,
  output pc_t        o_fs_to_ds_pc,
  output inst_t      o_fs_to_ds_inst,
  // inst sram interface
  output logic       o_inst_sram_en,
  output sram_addr_t o_inst_sram_addr,
  input  sram_data_t i_inst_sram_rdata
);

  logic  fs_valid;
  pc_t   fs_pc;
  inst_t fs_inst;

  // fetch never waits on decode.
  assign o_fs_to_ds_valid = fs_valid;

  assign o_fs_to_ds_pc   = fs_pc;
  assign o_fs_to_ds_inst = fs_inst;

  fetch_pc u_pc (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_load      (o_fs_to_ds_valid),  // advance once the current word is handed over.
    .i_br_sel    (i_br_sel),
    .i_br_target (i_br_target),
    .o_pc        (fs_pc)
  );

  fetch_ifu u_ifu (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_pc              (fs_pc),
    .o_ifu_ready       (fs_valid),
    .o_inst            (fs_inst),
    .o_inst_sram_en    (o_inst_sram_en),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

endmodule

/* rtl/fetch_ifu.sv */
// two-phase instruction fetch unit; issues one sram read, then returns the word with a ready strobe.
module fetch_ifu
  import fetch_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  pc_t        i_pc,
  output logic       o_ifu_ready,
  output inst_t      o_inst,
  // inst sram interface
  output logic       o_inst_sram_en,
  output sram_addr_t o_inst_sram_addr,
  input  sram_data_t i_inst_sram_rdata
);

  ifu_state_e state_r;
  ifu_state_e state_next;

  always_comb begin
    case (state_r)
      REQ:     state_next = RESP;
      RESP:    state_next = REQ;
      default: state_next = REQ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_r <= REQ;
    end else begin
      state_r <= state_next;
    end
  end

  // read is issued in REQ, data lands in RESP.
  assign o_inst_sram_en   = (state_r == REQ);
  assign o_inst_sram_addr = i_pc;

  assign o_ifu_ready = (state_r == RESP);
  assign o_inst      = i_inst_sram_rdata; // sram output register is the instruction.

  // one delivery per read, never back to back.
  a_ready_single: assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_ifu_ready |=> !o_ifu_ready
  ) else $error("ifu ready high on two consecutive cycles");

endmodule

/* rtl/fetch_pc.sv */
// program counter register; steps by four or takes the branch target when the fetch stage loads it.
module fetch_pc
  import fetch_pkg::*;
(
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_load,      // high on the response cycle of the ifu.
  input  logic i_br_sel,
  input  pc_t  i_br_target,
  output pc_t  o_pc
);

  pc_t pc_r;
  pc_t pc_seq;
  pc_t pc_next;

  assign pc_seq  = pc_r + PC_STEP;
  assign pc_next = i_br_sel ? i_br_target : pc_seq; // decode overrides the sequential path.

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_r <= RESET_PC;
    end else if (i_load) begin
      pc_r <= pc_next;
    end
  end

  assign o_pc = pc_r;

  // the pc must stay on a word boundary.
  a_pc_aligned: assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", o_pc);

endmodule

/* rtl/fetch_pkg.sv */
// shared widths, types and constants of the fetch front end; import into every design module.
package fetch_pkg;

  localparam int PC_WD        = 32;
  localparam int INST_WD      = 32;
  localparam int SRAM_ADDR_WD = 32;
  localparam int SRAM_DATA_WD = 32;

  typedef logic [PC_WD-1:0]        pc_t;        // byte address of an instruction.
  typedef logic [INST_WD-1:0]      inst_t;      // raw instruction word.
  typedef logic [SRAM_ADDR_WD-1:0] sram_addr_t; // byte address on the inst sram port.
  typedef logic [SRAM_DATA_WD-1:0] sram_data_t; // read data on the inst sram port.

  // first fetch address after reset.
  localparam pc_t RESET_PC = 32'h0000_0000;

  // instruction rom geometry, word indexed by address bits 7:2.
  localparam int ROM_DEPTH = 64;
  localparam int ROM_AW    = 6;
  localparam int ROM_LSB   = 2;

  // major opcode of jal.
  localparam logic [6:0] OPCODE_JAL = 7'b110_1111;

  // sequential step of the pc.
  localparam pc_t PC_STEP = 32'd4;

  // fetch unit phases.
  typedef enum logic {
    REQ,  // sram enable high, address = pc.
    RESP  // read data valid, instruction handed to decode.
  } ifu_state_e;

endpackage

/* rtl/fetch_top.sv */
// top level of the fetch front end; connects fetch, decode and the instruction rom.
module fetch_top
  import fetch_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset,
  output logic  o_id_valid,
  output pc_t   o_id_pc,
  output inst_t o_id_inst,
  output logic  o_id_jump
);

  logic       fs_to_ds_valid;
  pc_t        fs_to_ds_pc;
  inst_t      fs_to_ds_inst;

  logic       br_sel;
  pc_t        br_target;

  logic       inst_sram_en;
  sram_addr_t inst_sram_addr;
  sram_data_t inst_sram_rdata;

  fetch_if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_br_sel          (br_sel),
    .i_br_target       (br_target),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds_pc     (fs_to_ds_pc),
    .o_fs_to_ds_inst   (fs_to_ds_inst),
    .o_inst_sram_en    (inst_sram_en),
    .o_inst_sram_addr  (inst_sram_addr),
    .i_inst_sram_rdata (inst_sram_rdata)
  );

  fetch_id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds_pc    (fs_to_ds_pc),
    .i_fs_to_ds_inst  (fs_to_ds_inst),
    .o_br_sel         (br_sel),
    .o_br_target      (br_target),
    .o_id_valid       (o_id_valid),
    .o_id_pc          (o_id_pc),
    .o_id_inst        (o_id_inst),
    .o_id_jump        (o_id_jump)
  );

  // instruction sram model.
  inst_rom u_inst_rom (
    .i_clk   (i_clk),
    .i_en    (inst_sram_en),
    .i_addr  (inst_sram_addr),
    .o_rdata (inst_sram_rdata)
  );

endmodule

/* rtl/inst_rom.sv */
// synchronous-read instruction rom loaded from prog.hex; stands in for the instruction sram.
module inst_rom
  import fetch_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_en,
  input  sram_addr_t i_addr,
  output sram_data_t o_rdata
);

  sram_data_t mem [ROM_DEPTH];

  logic [ROM_AW-1:0] word_idx;
  sram_data_t        rdata_r;

  initial begin
    $readmemh("prog.hex", mem);
  end

  assign word_idx = i_addr[ROM_LSB+ROM_AW-1:ROM_LSB]; // byte address to word index.

  // data is valid on the cycle after an enabled read.
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      rdata_r <= mem[word_idx];
    end
  end

  assign o_rdata = rdata_r;

  // reads above the rom wrap silently, so flag them.
  a_addr_range: assert property (
    @(posedge i_clk)
    i_en |-> (i_addr[SRAM_ADDR_WD-1:ROM_LSB+ROM_AW] == '0)
  ) else $error("rom read out of range: %h", i_addr);

endmodule
